// File: common/dcache_defs.svh
// Width and geometry macros for the 2-way data cache
// Word address splits as tag | index | offset

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// CPU word address and data word
`define DC_ADDR_W   19
`define DC_DATA_W   16

// Byte lanes in one data word
`define DC_BE_W     2

// 256 sets of 8-word lines
`define DC_INDEX_W  8
`define DC_OFFSET_W 3

// Whatever is left of the word address above index and offset
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`endif

// File: common/dcache_pkg.sv
// Shared types of the data cache
// Address fields, CPU and memory requests, tag entries and enums

`include "dcache_defs.svh"

package dcache_pkg;

    // Word address broken into its cache fields
    typedef struct packed {
        logic [`DC_TAG_W-1:0]    tag;
        logic [`DC_INDEX_W-1:0]  index;
        logic [`DC_OFFSET_W-1:0] offset;
    } dc_addr_t;

    // One CPU access, held stable until the ack
    typedef struct packed {
        dc_addr_t              addr;
        logic [`DC_DATA_W-1:0] wdata;
        logic                  wr_en;
        logic [`DC_BE_W-1:0]   bytesel;
    } cpu_req_t;

    // Burst opcode on the memory side
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // One beat of a line burst, always a whole word
    typedef struct packed {
        dc_addr_t              addr;
        logic [`DC_DATA_W-1:0] wdata;
        mem_op_e               op;
    } mem_req_t;

    // State of one way in one set
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_LOOKUP    = 2'd1,
        ST_WRITEBACK = 2'd2,
        ST_FILL      = 2'd3
    } cache_state_e;

endpackage

// File: dcache/dcache_ctrl.sv
// Cache controller FSM: lookup, dirty write-back and line fill
// Drives the memory burst, the CPU ack and the store strobes

`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    // CPU side
    input  logic                     cpu_access,
    input  dcache_pkg::cpu_req_t     cpu_req,
    output logic                     cpu_ack,
    // Memory side
    output logic                     mem_access,
    output dcache_pkg::mem_req_t     mem_req,
    input  logic                     mem_ack,
    // Tag store
    output dcache_pkg::dc_addr_t     lookup_addr,
    input  logic                     hit,
    input  logic                     hit_way,
    input  logic                     victim_way,
    input  dcache_pkg::tag_entry_t   victim,
    output logic                     hit_update,
    output logic                     fill_start,
    output logic                     fill_done,
    // Data store
    output logic                     cpu_write,
    output logic                     line_write,
    output logic                     line_way,
    output logic [`DC_OFFSET_W-1:0]  line_offset,
    input  logic [`DC_DATA_W-1:0]    wb_data
);

    dcache_pkg::cache_state_e state_q;
    dcache_pkg::cache_state_e state_d;
    dcache_pkg::cpu_req_t     req_q;
    logic [`DC_TAG_W-1:0]     mem_tag_q;
    logic [`DC_OFFSET_W-1:0]  cnt_q;
    logic                     way_q;
    logic                     miss;
    logic                     wb_needed;
    logic                     beat_done;
    logic                     last_beat;

    // ------------------------------------------------------------------
    // Decode of the current cycle
    // ------------------------------------------------------------------
    assign miss      = (state_q == dcache_pkg::ST_LOOKUP) && !hit;
    assign wb_needed = victim.valid && victim.dirty;
    assign beat_done = mem_access && mem_ack;
    assign last_beat = beat_done && (cnt_q == '1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            dcache_pkg::ST_IDLE: begin
                if (cpu_access)
                    state_d = dcache_pkg::ST_LOOKUP;
            end
            dcache_pkg::ST_LOOKUP: begin
                if (hit)
                    state_d = dcache_pkg::ST_IDLE;
                else if (wb_needed)
                    state_d = dcache_pkg::ST_WRITEBACK;
                else
                    state_d = dcache_pkg::ST_FILL;
            end
            dcache_pkg::ST_WRITEBACK: begin
                if (last_beat)
                    state_d = dcache_pkg::ST_FILL;
            end
            dcache_pkg::ST_FILL: begin
                // Back to lookup, which then hits on the new line
                if (last_beat)
                    state_d = dcache_pkg::ST_LOOKUP;
            end
            default: state_d = dcache_pkg::ST_IDLE;
        endcase
    end

    // ------------------------------------------------------------------
    // State, beat counter and chosen way
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= dcache_pkg::ST_IDLE;
            cnt_q   <= '0;
            way_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // Eight beats wrap the counter back to zero
            if (beat_done)
                cnt_q <= cnt_q + 1'b1;
            if (miss)
                way_q <= victim_way;
        end
    end

    // Request latch and burst tag
    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::ST_IDLE && cpu_access)
            req_q <= cpu_req;
        if (miss)
            mem_tag_q <= wb_needed ? victim.tag : req_q.addr.tag;
        else if (state_q == dcache_pkg::ST_WRITEBACK && last_beat)
            mem_tag_q <= req_q.addr.tag;
    end

    // ------------------------------------------------------------------
    // Store strobes
    // ------------------------------------------------------------------
    assign lookup_addr = (state_q == dcache_pkg::ST_IDLE) ? cpu_req.addr : req_q.addr;
    assign cpu_ack     = (state_q == dcache_pkg::ST_LOOKUP) && hit;
    assign hit_update  = cpu_ack;
    assign cpu_write   = cpu_ack && req_q.wr_en;
    assign fill_start  = miss;
    assign fill_done   = (state_q == dcache_pkg::ST_FILL) && last_beat;
    assign line_write  = (state_q == dcache_pkg::ST_FILL) && beat_done;

    // Way is not latched yet during lookup
    assign line_way = (state_q == dcache_pkg::ST_LOOKUP) ? (hit ? hit_way : victim_way) : way_q;

    // Write-back reads run one word ahead so the RAM output is ready for the next beat
    assign line_offset = (state_q == dcache_pkg::ST_WRITEBACK && beat_done) ?
                         cnt_q + 1'b1 : cnt_q;

    // ------------------------------------------------------------------
    // Memory burst
    // ------------------------------------------------------------------
    assign mem_access = (state_q == dcache_pkg::ST_WRITEBACK) ||
                        (state_q == dcache_pkg::ST_FILL);

    always_comb begin
        mem_req.addr.tag    = mem_tag_q;
        mem_req.addr.index  = req_q.addr.index;
        mem_req.addr.offset = cnt_q;
        if (state_q == dcache_pkg::ST_WRITEBACK) begin
            mem_req.wdata = wb_data;
            mem_req.op    = dcache_pkg::MEM_WRITE;
        end else begin
            mem_req.wdata = '0;
            mem_req.op    = dcache_pkg::MEM_READ;
        end
    end

    // The acked request is still the one the CPU presented at lookup
    a_ack_on_held_req: assert property (
        @(posedge clk) disable iff (reset)
        cpu_ack |-> cpu_access && (cpu_req == req_q)
    );

    // A beat waiting for its ack keeps address, data and opcode
    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_access && !mem_ack |=> $stable(mem_req)
    );

endmodule

// File: dcache/dcache_tag_store.sv
// Tag, valid, dirty and LRU state for both ways
// Hit detection, LRU victim choice and the per-set updates

`include "dcache_defs.svh"

module dcache_tag_store (
    input  logic                   clk,
    input  logic                   reset,
    input  dcache_pkg::dc_addr_t   lookup_addr,
    output logic                   hit,
    output logic                   hit_way,
    output logic                   victim_way,
    output dcache_pkg::tag_entry_t victim,
    input  logic                   hit_update,
    input  logic                   cpu_wr_en,
    input  logic                   fill_start,
    input  logic                   fill_done,
    input  logic                   fill_way
);

    localparam int SETS = 1 << `DC_INDEX_W;

    logic [`DC_TAG_W-1:0]   tag_mem [2][SETS];
    logic [`DC_TAG_W-1:0]   tag_rd [2];
    logic [1:0][SETS-1:0]   valid_q;
    logic [1:0][SETS-1:0]   dirty_q;
    logic [SETS-1:0]        lru_q;
    logic [`DC_INDEX_W-1:0] idx_q;
    dcache_pkg::tag_entry_t entry [2];
    logic [1:0]             way_hit;

    // ------------------------------------------------------------------
    // Tag RAMs, read one cycle after the address
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (fill_start)
            tag_mem[fill_way][lookup_addr.index] <= lookup_addr.tag;
        for (int w = 0; w < 2; w++)
            tag_rd[w] <= tag_mem[w][lookup_addr.index];
    end

    // ------------------------------------------------------------------
    // Valid, dirty and LRU flags
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
            idx_q   <= '0;
        end else begin
            idx_q <= lookup_addr.index;
            // New tag goes in invalid and clean until the last beat lands
            if (fill_start) begin
                valid_q[fill_way][lookup_addr.index] <= 1'b0;
                dirty_q[fill_way][lookup_addr.index] <= 1'b0;
            end
            if (fill_done)
                valid_q[fill_way][lookup_addr.index] <= 1'b1;
            if (hit_update) begin
                // LRU bit names the way to replace next
                lru_q[lookup_addr.index] <= ~hit_way;
                if (cpu_wr_en)
                    dirty_q[hit_way][lookup_addr.index] <= 1'b1;
            end
        end
    end

    // Flags come from registers, so a fill that just finished is seen at once
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            entry[w].valid = valid_q[w][idx_q];
            entry[w].dirty = dirty_q[w][idx_q];
            entry[w].tag   = tag_rd[w];
            way_hit[w]     = entry[w].valid && (entry[w].tag == lookup_addr.tag);
        end
    end

    assign hit        = |way_hit;
    assign hit_way    = way_hit[1];
    assign victim_way = lru_q[idx_q];
    assign victim     = victim_way ? entry[1] : entry[0];

    // A line is only filled after a miss in its set, so one tag never sits in both ways
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (reset)
        !(way_hit[0] && way_hit[1])
    );

endmodule

// File: dcache/dcache_data_store.sv
// Line data RAMs, one 2048-word RAM per way
// Port A serves CPU reads and byte-lane write hits, port B fills and write-backs

`include "dcache_defs.svh"

module dcache_data_store (
    input  logic                    clk,
    input  dcache_pkg::dc_addr_t    lookup_addr,
    input  logic [`DC_DATA_W-1:0]   cpu_wdata,
    input  logic [`DC_BE_W-1:0]     cpu_bytesel,
    input  logic                    cpu_write,
    input  logic                    hit_way,
    output logic [`DC_DATA_W-1:0]   rdata,
    input  logic                    line_write,
    input  logic                    line_way,
    input  logic [`DC_OFFSET_W-1:0] line_offset,
    input  logic [`DC_DATA_W-1:0]   fill_data,
    output logic [`DC_DATA_W-1:0]   wb_data
);

    localparam int DEPTH  = 1 << (`DC_INDEX_W + `DC_OFFSET_W);
    localparam int LANE_W = `DC_DATA_W / `DC_BE_W;

    logic [`DC_INDEX_W+`DC_OFFSET_W-1:0] addr_a;
    logic [`DC_INDEX_W+`DC_OFFSET_W-1:0] addr_b;

    assign addr_a = {lookup_addr.index, lookup_addr.offset};
    // Set index stays latched in lookup_addr for the whole miss
    assign addr_b = {lookup_addr.index, line_offset};

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [`DC_DATA_W-1:0] mem [DEPTH];
        logic [`DC_DATA_W-1:0] rd_a;
        logic [`DC_DATA_W-1:0] rd_b;
        logic                  we_a;
        logic                  we_b;

        assign we_a = cpu_write && (hit_way == 1'(w));
        assign we_b = line_write && (line_way == 1'(w));

        always_ff @(posedge clk) begin
            for (int lane = 0; lane < `DC_BE_W; lane++) begin
                if (we_a && cpu_bytesel[lane])
                    mem[addr_a][lane*LANE_W +: LANE_W] <= cpu_wdata[lane*LANE_W +: LANE_W];
            end
            if (we_b)
                mem[addr_b] <= fill_data;
            // Last fill beat and the relookup read meet on the same word
            if (we_b && addr_b == addr_a)
                rd_a <= fill_data;
            else
                rd_a <= mem[addr_a];
            rd_b <= mem[addr_b];
        end
    end

    assign rdata   = hit_way ? g_way[1].rd_a : g_way[0].rd_a;
    assign wb_data = line_way ? g_way[1].rd_b : g_way[0].rd_b;

endmodule

// File: dcache/dcache_top.sv
// Top level of the 2-way write-back data cache
// Connects the controller FSM to the tag store and the line data store

`include "dcache_defs.svh"

module dcache_top (
    input  logic                  clk,
    input  logic                  reset,
    // CPU side
    input  logic                  cpu_access,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output logic                  cpu_ack,
    output logic [`DC_DATA_W-1:0] cpu_rdata,
    // Memory side
    output logic                  mem_access,
    output dcache_pkg::mem_req_t  mem_req,
    input  logic                  mem_ack,
    input  logic [`DC_DATA_W-1:0] mem_rdata
);

    dcache_pkg::dc_addr_t   lookup_addr;
    dcache_pkg::tag_entry_t victim;
    logic                   hit;
    logic                   hit_way;
    logic                   victim_way;
    logic                   hit_update;
    logic                   fill_start;
    logic                   fill_done;
    logic                   cpu_write;
    logic                   line_write;
    logic                   line_way;
    logic [`DC_OFFSET_W-1:0] line_offset;
    logic [`DC_DATA_W-1:0]  wb_data;

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cpu_access  (cpu_access),
        .cpu_req     (cpu_req),
        .cpu_ack     (cpu_ack),
        .mem_access  (mem_access),
        .mem_req     (mem_req),
        .mem_ack     (mem_ack),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim      (victim),
        .hit_update  (hit_update),
        .fill_start  (fill_start),
        .fill_done   (fill_done),
        .cpu_write   (cpu_write),
        .line_write  (line_write),
        .line_way    (line_way),
        .line_offset (line_offset),
        .wb_data     (wb_data)
    );

    // The fill port uses the controller's chosen way for both tags and data
    dcache_tag_store u_tag_store (
        .clk         (clk),
        .reset       (reset),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .victim      (victim),
        .hit_update  (hit_update),
        .cpu_wr_en   (cpu_write),
        .fill_start  (fill_start),
        .fill_done   (fill_done),
        .fill_way    (line_way)
    );

    // Write data comes straight from the CPU, which holds it until the ack
    dcache_data_store u_data_store (
        .clk         (clk),
        .lookup_addr (lookup_addr),
        .cpu_wdata   (cpu_req.wdata),
        .cpu_bytesel (cpu_req.bytesel),
        .cpu_write   (cpu_write),
        .hit_way     (hit_way),
        .rdata       (cpu_rdata),
        .line_write  (line_write),
        .line_way    (line_way),
        .line_offset (line_offset),
        .fill_data   (mem_rdata),
        .wb_data     (wb_data)
    );

endmodule

// File: testbench/tb_dcache.sv
// Testbench for the 2-way data cache
// Clock, reset, burst memory model, reference model, random traffic and report

`include "dcache_defs.svh"

module tb_dcache;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS       = 1 << `DC_ADDR_W;
    localparam int ACK_TIMEOUT = 200;
    // Request edge plus the edge that takes the ack
    localparam int HIT_EDGES   = 2;
    localparam int LANE_W      = `DC_DATA_W / `DC_BE_W;

    logic                   clk;
    logic                   reset;
    logic                   cpu_access;
    dcache_pkg::cpu_req_t   cpu_req;
    logic                   cpu_ack;
    logic [`DC_DATA_W-1:0]  cpu_rdata;
    logic                   mem_access;
    dcache_pkg::mem_req_t   mem_req;
    logic                   mem_ack;
    logic [`DC_DATA_W-1:0]  mem_rdata;

    logic [`DC_DATA_W-1:0]  mem_arr [WORDS];
    logic [`DC_DATA_W-1:0]  model_mem [WORDS];
    logic [`DC_TAG_W-1:0]   tag_pool [6] = '{8'h00, 8'h01, 8'h3c, 8'h7e, 8'hc5, 8'hff};
    logic [`DC_INDEX_W-1:0] index_pool [4] = '{8'h00, 8'h5a, 8'ha3, 8'hff};
    integer                 seed = 11971;
    integer                 delay_seed;
    int                     errors;
    int                     burst_errors;
    int                     total_beats;
    int                     read_bursts;
    int                     write_bursts;
    int                     beat_idx;
    int                     tests_passed;
    int                     tests_failed;
    bit                     timed_out;

    dcache_top uut (
        .clk        (clk),
        .reset      (reset),
        .cpu_access (cpu_access),
        .cpu_req    (cpu_req),
        .cpu_ack    (cpu_ack),
        .cpu_rdata  (cpu_rdata),
        .mem_access (mem_access),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_rdata  (mem_rdata)
    );

    always #20 clk = ~clk;

    // Every address bit feeds the preset word
    function automatic logic [`DC_DATA_W-1:0] pattern_word(input logic [`DC_ADDR_W-1:0] a);
        return 16'(a * 19'd40503) ^ 16'(a >> 11) ^ 16'h5a3c;
    endfunction

    // ------------------------------------------------------------------
    // Memory model and burst monitor
    // ------------------------------------------------------------------
    initial begin : memory_model
        int                             delay;
        logic [`DC_ADDR_W-1:0]          beat_addr;
        logic [`DC_ADDR_W-`DC_OFFSET_W-1:0] line_q;
        dcache_pkg::mem_op_e            burst_op;
        delay     = -1;
        line_q    = '0;
        burst_op  = dcache_pkg::MEM_READ;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            mem_ack = 1'b0;
            if (!mem_access || reset) begin
                delay = -1;
            end else begin
                if (delay < 0)
                    delay = $unsigned($random(delay_seed)) % 4;
                if (delay > 0) begin
                    delay--;
                end else begin
                    beat_addr = mem_req.addr;
                    if (beat_idx == 0) begin
                        line_q   = beat_addr[`DC_ADDR_W-1:`DC_OFFSET_W];
                        burst_op = mem_req.op;
                    end
                    assert (int'(mem_req.addr.offset) == beat_idx) else begin
                        burst_errors++;
                        errors++;
                        $display("CHECK FAILED mem_req.addr.offset expected=%h actual=%h",
                                 beat_idx, mem_req.addr.offset);
                    end
                    assert (beat_addr[`DC_ADDR_W-1:`DC_OFFSET_W] == line_q &&
                            mem_req.op == burst_op) else begin
                        burst_errors++;
                        errors++;
                        $display("burst beat at %h left its line or changed opcode", beat_addr);
                    end
                    if (mem_req.op == dcache_pkg::MEM_WRITE) begin
                        assert (mem_req.wdata === model_mem[beat_addr]) else begin
                            burst_errors++;
                            errors++;
                            $display("CHECK FAILED mem_req.wdata addr=%h expected=%h actual=%h",
                                     beat_addr, model_mem[beat_addr], mem_req.wdata);
                        end
                        mem_arr[beat_addr] = mem_req.wdata;
                    end else begin
                        mem_rdata = mem_arr[beat_addr];
                    end
                    total_beats++;
                    beat_idx++;
                    if (beat_idx == 8) begin
                        beat_idx = 0;
                        if (burst_op == dcache_pkg::MEM_WRITE)
                            write_bursts++;
                        else
                            read_bursts++;
                    end
                    delay   = -1;
                    mem_ack = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // CPU side tasks
    // ------------------------------------------------------------------
    // Called at a falling edge, returns at a falling edge after the ack cycle
    task automatic cpu_transfer(input logic [`DC_ADDR_W-1:0] addr, input logic wr,
                                input logic [`DC_DATA_W-1:0] wdata,
                                input logic [`DC_BE_W-1:0] be,
                                output logic [`DC_DATA_W-1:0] rdata, output int edges);
        int waited;
        waited = 0;
        rdata  = '0;
        edges  = 0;
        if (timed_out)
            return;
        cpu_req.addr    = dcache_pkg::dc_addr_t'(addr);
        cpu_req.wdata   = wdata;
        cpu_req.wr_en   = wr;
        cpu_req.bytesel = be;
        cpu_access      = 1'b1;
        do begin
            @(negedge clk);
            waited++;
        end while (!cpu_ack && waited < ACK_TIMEOUT);
        if (!cpu_ack) begin
            timed_out  = 1'b1;
            errors++;
            cpu_access = 1'b0;
            $display("timeout: no cpu_ack within %0d cycles for address %h", ACK_TIMEOUT, addr);
            return;
        end
        rdata = cpu_rdata;
        edges = waited + 1;
        if (wr) begin
            for (int lane = 0; lane < `DC_BE_W; lane++)
                if (be[lane])
                    model_mem[addr][lane*LANE_W +: LANE_W] = wdata[lane*LANE_W +: LANE_W];
        end
        @(negedge clk);
        cpu_access = 1'b0;
    endtask

    task automatic check_read(input logic [`DC_ADDR_W-1:0] addr,
                              input logic [`DC_DATA_W-1:0] rdata);
        if (timed_out)
            return;
        assert (rdata === model_mem[addr]) else begin
            errors++;
            $display("CHECK FAILED cpu_rdata addr=%h expected=%h actual=%h",
                     addr, model_mem[addr], rdata);
        end
    endtask

    // Few indexes and tags, so lines keep fighting over the two ways
    task automatic pick_addr(output logic [`DC_ADDR_W-1:0] addr);
        int t;
        int i;
        t    = $unsigned($random(seed)) % 6;
        i    = $unsigned($random(seed)) % 4;
        addr = {tag_pool[t], index_pool[i], 3'($random(seed))};
    endtask

    task automatic report_test(input int num, input string name, input int err_mark);
        if (errors == err_mark) begin
            tests_passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - err_mark);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin : main_sequence
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] rdata;
        int                    edges;
        int                    err_mark;
        int                    beats_mark;
        int                    waited;
        int                    mismatches;
        delay_seed = $random(seed);
        clk        = 1'b0;
        reset      = 1'b1;
        cpu_access = 1'b0;
        cpu_req    = '0;
        for (int a = 0; a < WORDS; a++) begin
            mem_arr[a]   = pattern_word(19'(a));
            model_mem[a] = pattern_word(19'(a));
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        err_mark = errors;
        repeat (5) begin
            @(negedge clk);
            assert (!cpu_ack && !mem_access) else begin
                errors++;
                $display("CHECK FAILED cpu_ack/mem_access expected=0/0 actual=%h/%h",
                         cpu_ack, mem_access);
            end
        end
        report_test(1, "idle after reset", err_mark);

        err_mark = errors;
        for (int i = 0; i < 300 && !timed_out; i++) begin
            pick_addr(addr);
            if (($random(seed) & 1) == 1) begin
                cpu_transfer(addr, 1'b1, 16'($random(seed)), 2'b11, rdata, edges);
            end else begin
                cpu_transfer(addr, 1'b0, '0, '0, rdata, edges);
                check_read(addr, rdata);
            end
        end
        report_test(2, "random reads and writes", err_mark);

        err_mark = errors;
        for (int i = 0; i < 80 && !timed_out; i++) begin
            pick_addr(addr);
            cpu_transfer(addr, 1'b1, 16'($random(seed)), 2'($random(seed)), rdata, edges);
            cpu_transfer(addr, 1'b0, '0, '0, rdata, edges);
            check_read(addr, rdata);
            cpu_transfer(addr ^ 19'd1, 1'b0, '0, '0, rdata, edges);
            check_read(addr ^ 19'd1, rdata);
        end
        report_test(3, "byte-lane writes", err_mark);

        err_mark = errors;
        for (int i = 0; i < 40 && !timed_out; i++) begin
            pick_addr(addr);
            cpu_transfer(addr, 1'b0, '0, '0, rdata, edges);
            beats_mark = total_beats;
            cpu_transfer(addr, 1'b0, '0, '0, rdata, edges);
            check_read(addr, rdata);
            assert (timed_out || (edges == HIT_EDGES && total_beats == beats_mark)) else begin
                errors++;
                $display("repeat read of %h took %0d edges and %0d memory beats",
                         addr, edges, total_beats - beats_mark);
            end
        end
        report_test(4, "hit timing", err_mark);

        err_mark = errors;
        assert (burst_errors == 0 && beat_idx == 0 && !mem_access) else begin
            errors++;
            $display("burst monitor saw %0d bad beats with %0d beats left open",
                     burst_errors, beat_idx);
        end
        assert (read_bursts > 0 && write_bursts > 0) else begin
            errors++;
            $display("traffic gave %0d fill and %0d write-back bursts, expected both kinds",
                     read_bursts, write_bursts);
        end
        report_test(5, "burst format", err_mark);

        // Two fresh tags per set push every dirty line out to memory
        err_mark = errors;
        foreach (index_pool[k]) begin
            for (int n = 0; n < 2 && !timed_out; n++) begin
                addr = {(n == 0) ? 8'h42 : 8'h99, index_pool[k], 3'($random(seed))};
                cpu_transfer(addr, 1'b0, '0, '0, rdata, edges);
                check_read(addr, rdata);
            end
        end
        waited = 0;
        while (mem_access && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (mem_access) begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: memory burst still running after the flush reads");
        end
        mismatches = 0;
        for (int a = 0; a < WORDS; a++) begin
            assert (mem_arr[a] === model_mem[a]) else begin
                mismatches++;
                errors++;
                if (mismatches <= 8)
                    $display("CHECK FAILED mem_arr addr=%h expected=%h actual=%h",
                             19'(a), model_mem[a], mem_arr[a]);
            end
        end
        report_test(6, "final memory contents", err_mark);

        $display("tests: %0d ok, %0d with errors, %0d check errors in total",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && !timed_out)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: all.f
+incdir+common
common/dcache_pkg.sv
dcache/dcache_ctrl.sv
dcache/dcache_tag_store.sv
dcache/dcache_data_store.sv
dcache/dcache_top.sv
testbench/tb_dcache.sv

// File: Makefile
# Verilator build, run, lint and clean for the data cache testbench

TOP := tb_dcache

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "=== PASS ==="

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/1ps \
		-f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
